//--- common/mbox_consts.svh
// memory box sizing constants, included by the package and by RTL that sizes arrays
`ifndef MBOX_CONSTS_SVH
`define MBOX_CONSTS_SVH

// data word width of the memory box
`define MBOX_WORD_W 36

// number of MB registers behind the MB select
`define MBOX_NUM_MB 4

// channel buffer RAM
`define MBOX_CHBUF_DEPTH 128
`define MBOX_CHBUF_AW 7

// channel command word buffer
`define MBOX_CCW_DEPTH 4
`define MBOX_CCW_AW 2

`endif

//--- common/mboxPkg.sv
// memory box types, referenced by scoped name from the RTL and the testbench
`default_nettype none

`include "mbox_consts.svh"

package mboxPkg;

  // one memory word
  typedef logic [`MBOX_WORD_W-1:0] word36;

  // memory-to-cache source
  typedef enum logic [1:0] {
    mtcAr      = 2'd0,
    mtcMb      = 2'd1,
    mtcMemData = 2'd2,
    mtcChReg   = 2'd3
  } memToCacheSelE;

  // MB input source
  typedef enum logic [2:0] {
    inCache   = 3'd0,
    inAr      = 3'd1,
    inChBuf   = 3'd2,
    inMemData = 3'd3,
    inCcwMix  = 3'd4
  } mbInSelE;

  // MB register file strobes and select
  typedef struct packed {
    logic [`MBOX_NUM_MB-1:0]         mbLoad;
    logic                            selLoad;
    logic [$clog2(`MBOX_NUM_MB)-1:0] selIn;
  } mbCtlT;

  // channel buffer, channel register and CCW buffer controls
  typedef struct packed {
    logic                      chBufWr;
    logic [`MBOX_CHBUF_AW-1:0] chBufAdr;
    logic                      bufMbSel;
    logic                      chLoad;
    logic                      chRegLoad;
    logic                      chReverse;
    logic                      cbusOutHold;
    logic                      ccwBufWr;
    logic [`MBOX_CCW_AW-1:0]   ccwBufAdr;
  } chanCtlT;

  // data routing controls
  typedef struct packed {
    logic          memToCacheEn;
    memToCacheSelE memToCacheSel;
    mbInSelE       mbInSel;
    logic          mixMbSel;
    logic          nxmAny;
    logic          kiPaging;
  } routeCtlT;

endpackage

`default_nettype wire

//--- hw/mbRegFile.sv
// four MB registers with a registered bank select driving the MB bus and its parity
`timescale 1ns/1ps
`default_nettype none

`include "mbox_consts.svh"

module mbRegFile (
  input  wire                   MBOX,
  input  wire                   rstN,
  input  wire mboxPkg::mbCtlT   mbCtl,
  input  wire mboxPkg::word36   mbIn,
  output mboxPkg::word36        mb,
  output logic                  mbParOdd
);

  localparam int SelW = $clog2(`MBOX_NUM_MB);

  // MB0..MB3
  mboxPkg::word36 mbReg [`MBOX_NUM_MB];

  // bank select, loaded only on selLoad
  logic [SelW-1:0] mbSel;

  // each register has its own load strobe, several may load the same word
  always_ff @(posedge MBOX) begin
    if (!rstN) begin
      for (int i = 0; i < `MBOX_NUM_MB; i++) begin
        mbReg[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `MBOX_NUM_MB; i++) begin
        if (mbCtl.mbLoad[i]) begin
          mbReg[i] <= mbIn;
        end
      end
    end
  end

  always_ff @(posedge MBOX) begin
    if (!rstN) begin
      mbSel <= '0;
    end else if (mbCtl.selLoad) begin
      mbSel <= mbCtl.selIn;
    end
  end

  // MB bus follows the selected register without an extra stage
  always_comb begin
    mb = mbReg[mbSel];
  end

  // odd parity over the whole bus
  always_comb begin
    mbParOdd = ^mb;
  end

endmodule

`default_nettype wire

//--- hw/chanBuf.sv
// channel buffer RAM, channel register, CCW buffer and held CBUS output register
`timescale 1ns/1ps
`default_nettype none

`include "mbox_consts.svh"

module chanBuf (
  input  wire                   MBOX,
  input  wire                   rstN,
  input  wire mboxPkg::chanCtlT chanCtl,
  input  wire mboxPkg::word36   mb,
  input  wire mboxPkg::word36   cbusD,
  input  wire mboxPkg::word36   ccwBufIn,
  output mboxPkg::word36        chReg,
  output mboxPkg::word36        mbChBuf,
  output mboxPkg::word36        cbusOut,
  output mboxPkg::word36        ccwWord
);

  localparam int HalfW = `MBOX_WORD_W / 2;

  // storage arrays
  mboxPkg::word36 chBufMem [`MBOX_CHBUF_DEPTH];
  mboxPkg::word36 ccwMem [`MBOX_CCW_DEPTH];

  mboxPkg::word36 chBufIn;
  mboxPkg::word36 chBufRd;
  mboxPkg::word36 chRegNext;

  // write source is MB or the channel register
  always_comb begin
    chBufIn = chanCtl.bufMbSel ? mb : chReg;
  end

  // asynchronous read port, so a same-edge write is seen only afterwards
  always_comb begin
    chBufRd = chBufMem[chanCtl.chBufAdr];
  end

  always_ff @(posedge MBOX) begin
    if (chanCtl.chBufWr) begin
      chBufMem[chanCtl.chBufAdr] <= chBufIn;
    end
  end

  // halfword swap for reversed channel transfers
  always_comb begin
    if (chanCtl.chReverse) begin
      chRegNext = {cbusD[HalfW-1:0], cbusD[`MBOX_WORD_W-1:HalfW]};
    end else begin
      chRegNext = cbusD;
    end
  end

  always_ff @(posedge MBOX) begin
    if (!rstN) begin
      chReg <= '0;
    end else if (chanCtl.chRegLoad) begin
      chReg <= chRegNext;
    end
  end

  // MB side copy of the buffer word
  always_ff @(posedge MBOX) begin
    if (!rstN) begin
      mbChBuf <= '0;
    end else if (chanCtl.chLoad) begin
      mbChBuf <= chBufRd;
    end
  end

  // CBUS side tracks the buffer every cycle until held
  always_ff @(posedge MBOX) begin
    if (!rstN) begin
      cbusOut <= '0;
    end else if (!chanCtl.cbusOutHold) begin
      cbusOut <= chBufRd;
    end
  end

  // CCW buffer, written and read at the same address
  always_ff @(posedge MBOX) begin
    if (chanCtl.ccwBufWr) begin
      ccwMem[chanCtl.ccwBufAdr] <= ccwBufIn;
    end
  end

  always_comb begin
    ccwWord = ccwMem[chanCtl.ccwBufAdr];
  end

endmodule

`default_nettype wire

//--- hw/mbRouter.sv
// combinational selection of the MB input, memory-to-cache and page table input words
`timescale 1ns/1ps
`default_nettype none

module mbRouter (
  input  wire mboxPkg::routeCtlT routeCtl,
  input  wire mboxPkg::word36    ar,
  input  wire mboxPkg::word36    cacheData,
  input  wire mboxPkg::word36    memDataIn,
  input  wire mboxPkg::word36    mb,
  input  wire mboxPkg::word36    chReg,
  input  wire mboxPkg::word36    mbChBuf,
  input  wire mboxPkg::word36    ccwWord,
  output mboxPkg::word36         mbIn,
  output mboxPkg::word36         memToCache,
  output mboxPkg::word36         ptIn
);

  mboxPkg::word36 ccwMix;
  mboxPkg::word36 mbInRaw;

  // channel command mix, MB or the addressed CCW word
  always_comb begin
    ccwMix = routeCtl.mixMbSel ? mb : ccwWord;
  end

  always_comb begin
    case (routeCtl.mbInSel)
      mboxPkg::inCache: begin
        mbInRaw = cacheData;
      end
      mboxPkg::inAr: begin
        mbInRaw = ar;
      end
      mboxPkg::inChBuf: begin
        mbInRaw = mbChBuf;
      end
      mboxPkg::inMemData: begin
        mbInRaw = memDataIn;
      end
      mboxPkg::inCcwMix: begin
        mbInRaw = ccwMix;
      end
      default: begin
        mbInRaw = '0;
      end
    endcase
  end

  // nonexistent memory blanks the MB input
  always_comb begin
    mbIn = routeCtl.nxmAny ? '0 : mbInRaw;
  end

  always_comb begin
    memToCache = '0;
    if (routeCtl.memToCacheEn) begin
      case (routeCtl.memToCacheSel)
        mboxPkg::mtcAr:      memToCache = ar;
        mboxPkg::mtcMb:      memToCache = mb;
        mboxPkg::mtcMemData: memToCache = memDataIn;
        mboxPkg::mtcChReg:   memToCache = chReg;
        default:             memToCache = '0;
      endcase
    end
  end

  // KI paging takes page table data from MB, otherwise from AR
  always_comb begin
    ptIn = routeCtl.kiPaging ? mb : ar;
  end

endmodule

`default_nettype wire

//--- hw/mbox.sv
// memory buffer section top level, connects the MB registers, channel buffer and router
`timescale 1ns/1ps
`default_nettype none

module mbox (
  input  wire                    MBOX,
  input  wire                    rstN,
  input  wire mboxPkg::mbCtlT    mbCtl,
  input  wire mboxPkg::chanCtlT  chanCtl,
  input  wire mboxPkg::routeCtlT routeCtl,
  input  wire mboxPkg::word36    ar,
  input  wire mboxPkg::word36    cacheData,
  input  wire mboxPkg::word36    memDataIn,
  input  wire mboxPkg::word36    cbusD,
  input  wire mboxPkg::word36    ccwBufIn,
  output mboxPkg::word36         mb,
  output logic                   mbParOdd,
  output mboxPkg::word36         memToCache,
  output mboxPkg::word36         ptIn,
  output mboxPkg::word36         cbusOut,
  output mboxPkg::word36         mbChBuf,
  output mboxPkg::word36         chReg
);

  // router result back into the MB registers
  mboxPkg::word36 mbIn;

  // addressed CCW buffer word
  mboxPkg::word36 ccwWord;

  mbRegFile iMbRegFile (
    .MBOX     (MBOX),
    .rstN     (rstN),
    .mbCtl    (mbCtl),
    .mbIn     (mbIn),
    .mb       (mb),
    .mbParOdd (mbParOdd)
  );

  chanBuf iChanBuf (
    .MBOX     (MBOX),
    .rstN     (rstN),
    .chanCtl  (chanCtl),
    .mb       (mb),
    .cbusD    (cbusD),
    .ccwBufIn (ccwBufIn),
    .chReg    (chReg),
    .mbChBuf  (mbChBuf),
    .cbusOut  (cbusOut),
    .ccwWord  (ccwWord)
  );

  mbRouter iMbRouter (
    .routeCtl   (routeCtl),
    .ar         (ar),
    .cacheData  (cacheData),
    .memDataIn  (memDataIn),
    .mb         (mb),
    .chReg      (chReg),
    .mbChBuf    (mbChBuf),
    .ccwWord    (ccwWord),
    .mbIn       (mbIn),
    .memToCache (memToCache),
    .ptIn       (ptIn)
  );

endmodule

`default_nettype wire

//--- sim/mbox_asserts.sv
// concurrent checks on the memory box, bound into mbox by the testbench build
`timescale 1ns/1ps
`default_nettype none

`include "mbox_consts.svh"

module mboxAsserts (
  input wire                    MBOX,
  input wire                    rstN,
  input wire mboxPkg::mbCtlT    mbCtl,
  input wire mboxPkg::chanCtlT  chanCtl,
  input wire mboxPkg::routeCtlT routeCtl,
  input wire mboxPkg::word36    ar,
  input wire mboxPkg::word36    cacheData,
  input wire mboxPkg::word36    memDataIn,
  input wire mboxPkg::word36    cbusD,
  input wire mboxPkg::word36    mb,
  input wire                    mbParOdd,
  input wire mboxPkg::word36    memToCache,
  input wire mboxPkg::word36    ptIn,
  input wire mboxPkg::word36    cbusOut,
  input wire mboxPkg::word36    mbChBuf,
  input wire mboxPkg::word36    chReg,
  input wire mboxPkg::word36    mbIn,
  input wire mboxPkg::word36    ccwWord
);

  localparam int HalfW = `MBOX_WORD_W / 2;

  // number of failed assertions, watched by the testbench
  int failCount = 0;

  mboxPkg::word36 mbInExp;
  mboxPkg::word36 mtcExp;
  mboxPkg::word36 chRegExp;

  assign mbInExp = routeCtl.nxmAny ? '0 :
                   (routeCtl.mbInSel == mboxPkg::inCache)   ? cacheData :
                   (routeCtl.mbInSel == mboxPkg::inAr)      ? ar :
                   (routeCtl.mbInSel == mboxPkg::inChBuf)   ? mbChBuf :
                   (routeCtl.mbInSel == mboxPkg::inMemData) ? memDataIn :
                   (routeCtl.mixMbSel ? mb : ccwWord);

  assign mtcExp = !routeCtl.memToCacheEn ? '0 :
                  (routeCtl.memToCacheSel == mboxPkg::mtcAr)      ? ar :
                  (routeCtl.memToCacheSel == mboxPkg::mtcMb)      ? mb :
                  (routeCtl.memToCacheSel == mboxPkg::mtcMemData) ? memDataIn : chReg;

  // reversed transfers swap the two halfwords
  assign chRegExp = chanCtl.chReverse ? {cbusD[HalfW-1:0], cbusD[`MBOX_WORD_W-1:HalfW]} : cbusD;

  resetClears: assert property (@(posedge MBOX)
    !rstN |=> (mb == '0 && chReg == '0 && mbChBuf == '0 && cbusOut == '0))
    else begin
      $error("registers not cleared after reset");
      failCount++;
    end

  parityOdd: assert property (@(posedge MBOX) disable iff (!rstN) mbParOdd == ^mb)
    else begin
      $error("mbParOdd is not the XOR of mb");
      failCount++;
    end

  routeComb: assert property (@(posedge MBOX) disable iff (!rstN)
    mbIn == mbInExp && memToCache == mtcExp && ptIn == (routeCtl.kiPaging ? mb : ar))
    else begin
      $error("router output does not match its selected source");
      failCount++;
    end

  // with every register loading, the select cannot hide the new word
  mbLoadAll: assert property (@(posedge MBOX) disable iff (!rstN)
    &mbCtl.mbLoad |=> mb == $past(mbIn))
    else begin
      $error("mb does not show the word loaded into all registers");
      failCount++;
    end

  chRegLoaded: assert property (@(posedge MBOX) disable iff (!rstN)
    chanCtl.chRegLoad |=> chReg == $past(chRegExp))
    else begin
      $error("channel register load or halfword swap wrong");
      failCount++;
    end

  cbusHeld: assert property (@(posedge MBOX) disable iff (!rstN)
    chanCtl.cbusOutHold |=> cbusOut === $past(cbusOut))
    else begin
      $error("cbusOut changed while held");
      failCount++;
    end

endmodule

bind mbox mboxAsserts iMboxAsserts (.*);

`default_nettype wire

//--- sim/mboxTb.sv
// memory box testbench top with a reference model and RAM scoreboard, run from the Verilator build
`timescale 1ns/1ps
`default_nettype none

`include "mbox_consts.svh"

module mboxTb;

  localparam int MaxCycles = 400;
  localparam int HalfW = `MBOX_WORD_W / 2;

  logic MBOX;
  logic rstN;
  mboxPkg::mbCtlT mbCtl;
  mboxPkg::chanCtlT chanCtl;
  mboxPkg::routeCtlT routeCtl;
  mboxPkg::word36 ar;
  mboxPkg::word36 cacheData;
  mboxPkg::word36 memDataIn;
  mboxPkg::word36 cbusD;
  mboxPkg::word36 ccwBufIn;
  mboxPkg::word36 mb;
  mboxPkg::word36 memToCache;
  mboxPkg::word36 ptIn;
  mboxPkg::word36 cbusOut;
  mboxPkg::word36 mbChBuf;
  mboxPkg::word36 chReg;
  logic mbParOdd;

  // reference model and channel buffer scoreboard
  mboxPkg::word36 regM [`MBOX_NUM_MB];
  logic [1:0] selM;
  mboxPkg::word36 chRegM;
  mboxPkg::word36 mbChBufM;
  mboxPkg::word36 cbusOutM;
  logic cbusKnownM;
  mboxPkg::word36 sbMem [`MBOX_CHBUF_DEPTH];
  logic [`MBOX_CHBUF_DEPTH-1:0] sbValid;
  mboxPkg::word36 ccwM [`MBOX_CCW_DEPTH];
  int cycles;
  logic [31:0] r;

  mbox i_mbox (.*);

  initial begin
    MBOX = 1'b0;
    forever #4 MBOX = ~MBOX;
  end

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "mbox testbench stopped");
  endtask

  task automatic checkWord(input string name, input mboxPkg::word36 got,
                           input mboxPkg::word36 exp);
    if (got !== exp) begin
      failRun($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  function automatic mboxPkg::word36 randWord();
    logic [63:0] w;
    w = {$urandom(), $urandom()};
    return w[`MBOX_WORD_W-1:0];
  endfunction

  // MB input word as the routing rules give it
  function automatic mboxPkg::word36 expectMbIn();
    mboxPkg::word36 src;
    case (routeCtl.mbInSel)
      mboxPkg::inCache:   src = cacheData;
      mboxPkg::inAr:      src = ar;
      mboxPkg::inChBuf:   src = mbChBufM;
      mboxPkg::inMemData: src = memDataIn;
      default:            src = routeCtl.mixMbSel ? regM[selM] : ccwM[chanCtl.ccwBufAdr];
    endcase
    return routeCtl.nxmAny ? '0 : src;
  endfunction

  always @(posedge MBOX) begin : modelStep
    mboxPkg::word36 nextIn;
    mboxPkg::word36 wrData;
    nextIn = expectMbIn();
    wrData = chanCtl.bufMbSel ? regM[selM] : chRegM;
    if (!rstN) begin
      for (int i = 0; i < `MBOX_NUM_MB; i++) begin
        regM[i] = '0;
      end
      selM = '0;
      chRegM = '0;
      mbChBufM = '0;
      cbusOutM = '0;
      cbusKnownM = 1'b1;
    end else begin
      // load sees the old word on a same edge write
      if (chanCtl.chLoad) begin
        mbChBufM = sbMem[chanCtl.chBufAdr];
      end
      // CBUS copy reloads from the addressed word unless held
      if (!chanCtl.cbusOutHold) begin
        cbusOutM = sbMem[chanCtl.chBufAdr];
        cbusKnownM = sbValid[chanCtl.chBufAdr];
      end
      if (chanCtl.chBufWr) begin
        sbMem[chanCtl.chBufAdr] = wrData;
        sbValid[chanCtl.chBufAdr] = 1'b1;
      end
      if (chanCtl.ccwBufWr) begin
        ccwM[chanCtl.ccwBufAdr] = ccwBufIn;
      end
      if (chanCtl.chRegLoad) begin
        chRegM = chanCtl.chReverse ? {cbusD[HalfW-1:0], cbusD[`MBOX_WORD_W-1:HalfW]} : cbusD;
      end
      for (int i = 0; i < `MBOX_NUM_MB; i++) begin
        if (mbCtl.mbLoad[i]) begin
          regM[i] = nextIn;
        end
      end
      if (mbCtl.selLoad) begin
        selM = mbCtl.selIn;
      end
    end
  end

  always @(posedge MBOX) begin
    cycles = cycles + 1;
    if (cycles >= MaxCycles) begin
      failRun("timeout: the run did not finish within the cycle limit");
    end
  end

  always @(negedge MBOX) begin
    if (i_mbox.iMboxAsserts.failCount != 0) begin
      failRun("a bound assertion on mbox failed");
    end
  end

  // compare with the model at the next falling edge and drop the strobes
  task automatic nextCycle();
    @(negedge MBOX);
    checkWord("mb", mb, regM[selM]);
    checkWord("mbChBuf", mbChBuf, mbChBufM);
    checkWord("chReg", chReg, chRegM);
    if (cbusKnownM) begin
      checkWord("cbusOut", cbusOut, cbusOutM);
    end
    mbCtl.mbLoad = '0;
    mbCtl.selLoad = 1'b0;
    chanCtl.chBufWr = 1'b0;
    chanCtl.chLoad = 1'b0;
    chanCtl.chRegLoad = 1'b0;
    chanCtl.ccwBufWr = 1'b0;
  endtask

  task automatic bufOp(input logic [6:0] adr, input logic wr, input logic fromMb,
                       input logic load);
    nextCycle();
    chanCtl.chBufAdr = adr;
    chanCtl.chBufWr = wr;
    chanCtl.bufMbSel = fromMb;
    chanCtl.chLoad = load;
  endtask

  initial begin
    void'($urandom(45));
    rstN = 1'b0;
    mbCtl = '0;
    chanCtl = '0;
    routeCtl = '0;
    ar = '0;
    cacheData = '0;
    memDataIn = '0;
    cbusD = '0;
    ccwBufIn = '0;
    sbValid = '0;
    cycles = 0;
    repeat (3) @(negedge MBOX);
    rstN = 1'b1;
    checkWord("cbusOut", cbusOut, '0);
    checkWord("memToCache", memToCache, '0);

    // distinct words into each MB register, then walk the select
    routeCtl.mbInSel = mboxPkg::inAr;
    for (int i = 0; i < `MBOX_NUM_MB; i++) begin
      nextCycle();
      ar = randWord();
      mbCtl.mbLoad = 4'b0001 << i;
    end
    for (int i = `MBOX_NUM_MB - 1; i >= 0; i--) begin
      nextCycle();
      mbCtl.selLoad = 1'b1;
      mbCtl.selIn = 2'(i);
    end

    // channel register loaded swapped then straight
    for (int i = 0; i < 2; i++) begin
      nextCycle();
      cbusD = randWord();
      chanCtl.chRegLoad = 1'b1;
      chanCtl.chReverse = (i == 0);
    end

    // fill the CCW buffer, then load one word through the CCW mix
    for (int i = 0; i < `MBOX_CCW_DEPTH; i++) begin
      nextCycle();
      ccwBufIn = randWord();
      chanCtl.ccwBufWr = 1'b1;
      chanCtl.ccwBufAdr = 2'(i);
    end
    nextCycle();
    chanCtl.ccwBufAdr = 2'd2;
    routeCtl.mbInSel = mboxPkg::inCcwMix;
    routeCtl.mixMbSel = 1'b0;
    mbCtl.mbLoad = 4'b1111;

    // buffer writes from both sources, a same edge write and load, then a held CBUS
    bufOp(7'd5, 1'b1, 1'b1, 1'b0);
    bufOp(7'd6, 1'b1, 1'b0, 1'b0);
    bufOp(7'd5, 1'b1, 1'b0, 1'b1);
    bufOp(7'd6, 1'b0, 1'b0, 1'b1);
    chanCtl.cbusOutHold = 1'b1;
    bufOp(7'd5, 1'b1, 1'b1, 1'b0);
    bufOp(7'd5, 1'b0, 1'b0, 1'b1);
    chanCtl.cbusOutHold = 1'b0;

    for (int n = 0; n < 200; n++) begin
      nextCycle();
      r = $urandom();
      mbCtl.mbLoad = r[3:0];
      mbCtl.selLoad = r[4];
      mbCtl.selIn = r[6:5];
      chanCtl.chBufWr = r[7];
      chanCtl.chBufAdr = r[14:8];
      chanCtl.bufMbSel = r[15];
      chanCtl.chLoad = r[16] && sbValid[r[14:8]];
      chanCtl.chRegLoad = r[17];
      chanCtl.chReverse = r[18];
      chanCtl.cbusOutHold = r[19] & r[20];
      chanCtl.ccwBufWr = r[21];
      chanCtl.ccwBufAdr = r[23:22];
      routeCtl.memToCacheEn = r[24];
      routeCtl.memToCacheSel = mboxPkg::memToCacheSelE'(r[26:25]);
      routeCtl.mbInSel = mboxPkg::mbInSelE'(3'(r[31:27] % 5));
      r = $urandom();
      routeCtl.mixMbSel = r[0];
      routeCtl.nxmAny = r[1] & r[2] & r[3];
      routeCtl.kiPaging = r[4];
      ar = randWord();
      cacheData = randWord();
      memDataIn = randWord();
      cbusD = randWord();
      ccwBufIn = randWord();
    end

    nextCycle();
    if (i_mbox.iMboxAsserts.failCount != 0) begin
      failRun("a bound assertion on mbox failed");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- mbox.f
+incdir+common
common/mboxPkg.sv
hw/mbRegFile.sv
hw/chanBuf.sv
hw/mbRouter.sv
hw/mbox.sv
sim/mbox_asserts.sv
sim/mboxTb.sv

//--- Makefile
# Verilator build and run of the memory box testbench

VERILATOR ?= verilator
TOP       ?= mboxTb
RTL_TOP   ?= mbox
FILELIST  ?= mbox.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
ERR_LIMIT ?= 100
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall
RTL_SRCS  ?= common/mboxPkg.sv hw/mbRegFile.sv hw/chanBuf.sv hw/mbRouter.sv hw/mbox.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+$(ERR_LIMIT) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Simulation passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) +incdir+common $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
